/* include/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ======================================================================
// Core sizing.
// ======================================================================

`define CPU_XLEN        32              // Data and address width.
`define CPU_NREGS       16              // Register 0 always reads as zero.

// ======================================================================
// Fetch start point.
// ======================================================================

`define CPU_RESET_PC    32'h0000_0000   // First fetch address after reset.

`endif

/* verilog/cpu_isa_pkg.sv */
`include "cpu_consts.svh"

package cpu_isa_pkg;

        // Instruction opcodes, top nibble of the word.
        typedef enum logic [3:0]
        {
                OP_ADD  = 4'h0,         // rd = rs + rt.
                OP_SUB  = 4'h1,         // rd = rs - rt.
                OP_AND  = 4'h2,
                OP_OR   = 4'h3,
                OP_XOR  = 4'h4,
                OP_ADDI = 4'h5,         // rd = rs + sext(imm).
                OP_LUI  = 4'h6,         // rd = imm << 16.
                OP_LDW  = 4'h7,         // rd = mem[rs + sext(imm)].
                OP_STW  = 4'h8,         // Full word store of rt.
                OP_STB  = 4'h9,         // Low byte of rt, lane from address.
                OP_BEQ  = 4'hA,
                OP_BNE  = 4'hB,
                OP_JMP  = 4'hC,         // pc = imm * 4.
                OP_HALT = 4'hD,
                OP_NOP  = 4'hE
        } opcode_e;

        // Instruction word layout.
        typedef struct packed
        {
                opcode_e        opcode;         // Bits 31:28.
                logic [3:0]     rd;             // Bits 27:24.
                logic [3:0]     rs;             // Bits 23:20.
                logic [3:0]     rt;             // Bits 19:16.
                logic [15:0]    imm;            // Bits 15:0.
        } instr_t;

        // Word handed from fetch to execute.
        typedef struct packed
        {
                instr_t                 instr;
                logic [`CPU_XLEN-1:0]   pc;     // Address the word came from.
        } fetch_word_t;

        typedef enum logic [1:0]
        {
                ST_RUN          = 2'd0,
                ST_WAIT_MEM     = 2'd1,         // Load or store outstanding.
                ST_HALTED       = 2'd2          // Terminal.
        } exec_state_e;

endpackage

/* verilog/cpu_bus_pkg.sv */
`include "cpu_consts.svh"

package cpu_bus_pkg;

        // Data memory request from execute to memory access.
        typedef struct packed
        {
                logic                           read;
                logic                           write;
                logic [$clog2(`CPU_NREGS)-1:0]  rd;     // Load destination.
                logic [3:0]                     ben;    // One bit per byte lane.
                logic [`CPU_XLEN-1:0]           addr;
                logic [`CPU_XLEN-1:0]           wdata;  // Already lane shifted.
        } mem_req_t;

        // Load result returned for write-back.
        typedef struct packed
        {
                logic                           valid;  // Single cycle.
                logic [$clog2(`CPU_NREGS)-1:0]  rd;
                logic [`CPU_XLEN-1:0]           data;
        } load_wb_t;

endpackage

/* verilog/cpu_fetch.sv */
`include "cpu_consts.svh"

module cpu_fetch
(
        input   logic                           i_clk,
        input   logic                           i_rst_n,

        input   logic   [`CPU_XLEN-1:0]         i_iram_data,
        input   logic                           i_iram_stall,

        input   logic                           i_hold,
        input   logic                           i_mem_busy,
        input   logic                           i_redirect,
        input   logic   [`CPU_XLEN-1:0]         i_redirect_pc,

        output  logic                           o_iram_rd_en,
        output  logic   [`CPU_XLEN-1:0]         o_iram_addr,
        output  cpu_isa_pkg::fetch_word_t       o_fw,
        output  logic                           o_fw_valid
);

import cpu_isa_pkg::*;

logic                   rd_en_q;
logic [`CPU_XLEN-1:0]   addr_q;
fetch_word_t            fw_q;
logic                   fw_valid_q;
logic                   clear;
logic                   stall;
logic                   fetch_done;
logic                   port_busy;
logic                   slot_free;

// ======================================================================
// Clear and stall order.
// ======================================================================

always_comb
begin
        clear = 1'b0;
        stall = 1'b0;

        if      ( i_redirect )  clear = 1'b1;   // Wins over everything.
        else if ( i_mem_busy )  stall = 1'b1;
        else if ( i_hold )      stall = 1'b1;
end

assign fetch_done = rd_en_q && !i_iram_stall;   // Word valid this cycle.
assign port_busy  = rd_en_q && i_iram_stall;
assign slot_free  = !fw_valid_q || !stall;      // Empty or being drained.

// ======================================================================
// Request and holding register.
// ======================================================================

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                rd_en_q    <= 1'b0;
                addr_q     <= `CPU_RESET_PC;
                fw_valid_q <= 1'b0;
        end
        else
        begin
                if (clear)
                        fw_valid_q <= 1'b0;
                else if (fetch_done)
                        fw_valid_q <= 1'b1;
                else if (slot_free)
                        fw_valid_q <= 1'b0;

                // Address is frozen while the memory stalls.
                if (!port_busy)
                begin
                        if (clear)
                        begin
                                rd_en_q <= 1'b1;
                                addr_q  <= i_redirect_pc;
                        end
                        else if (fetch_done)
                        begin
                                rd_en_q <= 1'b0;        // Wait for a free slot.
                                addr_q  <= addr_q + `CPU_XLEN'(4);
                        end
                        else
                        begin
                                rd_en_q <= slot_free;
                        end
                end
        end
end

always_ff @(posedge i_clk)
begin
        if (fetch_done)
                fw_q <= '{instr: instr_t'(i_iram_data), pc: addr_q};
end

assign o_iram_rd_en = rd_en_q;
assign o_iram_addr  = addr_q;
assign o_fw         = fw_q;
assign o_fw_valid   = fw_valid_q;

// A stalled fetch here would slip past the redirect.
assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_redirect |-> !(o_iram_rd_en && i_iram_stall));

endmodule

/* verilog/cpu_execute.sv */
`include "cpu_consts.svh"

module cpu_execute
(
        input   logic                           i_clk,
        input   logic                           i_rst_n,

        input   cpu_isa_pkg::fetch_word_t       i_fw,
        input   logic                           i_fw_valid,
        input   logic                           i_mem_busy,
        input   cpu_bus_pkg::load_wb_t          i_load_wb,

        output  logic                           o_hold,
        output  logic                           o_redirect,
        output  logic   [`CPU_XLEN-1:0]         o_redirect_pc,
        output  cpu_bus_pkg::mem_req_t          o_mem_req,
        output  logic                           o_mem_req_valid,
        output  logic                           o_halted
);

import cpu_isa_pkg::*;

exec_state_e            state_q;
exec_state_e            state_nxt;
instr_t                 ins;
logic                   take;
logic [`CPU_XLEN-1:0]   regs_q [`CPU_NREGS];
logic [`CPU_XLEN-1:0]   rs_val;
logic [`CPU_XLEN-1:0]   rt_val;
logic [`CPU_XLEN-1:0]   imm_sx;
logic [`CPU_XLEN-1:0]   alu_res;
logic [`CPU_XLEN-1:0]   ls_addr;
logic                   alu_wr;
logic                   taken;

assign ins    = i_fw.instr;
assign o_hold = (state_q != ST_RUN) || i_mem_busy;
assign take   = i_fw_valid && !o_hold;          // Word consumed this cycle.

assign rs_val = (ins.rs == 4'd0) ? '0 : regs_q[ins.rs];
assign rt_val = (ins.rt == 4'd0) ? '0 : regs_q[ins.rt];
assign imm_sx = {{(`CPU_XLEN-16){ins.imm[15]}}, ins.imm};

// ======================================================================
// ALU and branch resolution.
// ======================================================================

always_comb
begin
        alu_res = '0;
        alu_wr  = 1'b1;

        case (ins.opcode)
        OP_ADD:  alu_res = rs_val + rt_val;
        OP_SUB:  alu_res = rs_val - rt_val;
        OP_AND:  alu_res = rs_val & rt_val;
        OP_OR:   alu_res = rs_val | rt_val;
        OP_XOR:  alu_res = rs_val ^ rt_val;
        OP_ADDI: alu_res = rs_val + imm_sx;
        OP_LUI:  alu_res = {ins.imm, 16'h0000};
        default: alu_wr  = 1'b0;               // No register result.
        endcase
end

always_comb
begin
        case (ins.opcode)
        OP_BEQ:  taken = (rs_val == rt_val);
        OP_BNE:  taken = (rs_val != rt_val);
        OP_JMP:  taken = 1'b1;
        default: taken = 1'b0;
        endcase
end

assign o_redirect    = take && taken;
assign o_redirect_pc = (ins.opcode == OP_JMP) ?
                       {{(`CPU_XLEN-18){1'b0}}, ins.imm, 2'b00} :
                       i_fw.pc + `CPU_XLEN'(4) + (imm_sx << 2);

// ======================================================================
// Load and store issue.
// ======================================================================

assign ls_addr = rs_val + imm_sx;

always_comb
begin
        o_mem_req.read  = (ins.opcode == OP_LDW);
        o_mem_req.write = (ins.opcode == OP_STW) || (ins.opcode == OP_STB);
        o_mem_req.rd    = ins.rd;
        o_mem_req.addr  = ls_addr;

        if (ins.opcode == OP_STB)
        begin
                o_mem_req.ben   = 4'b0001 << ls_addr[1:0];
                o_mem_req.wdata = {24'd0, rt_val[7:0]} << {ls_addr[1:0], 3'b000};
        end
        else
        begin
                o_mem_req.ben   = 4'b1111;
                o_mem_req.wdata = rt_val;
        end
end

assign o_mem_req_valid = take && (o_mem_req.read || o_mem_req.write);

always_comb
begin
        state_nxt = state_q;

        case (state_q)
        ST_RUN:
        begin
                if (take && ins.opcode == OP_HALT)
                        state_nxt = ST_HALTED;
                else if (o_mem_req_valid)
                        state_nxt = ST_WAIT_MEM;
        end
        ST_WAIT_MEM:
        begin
                if (!i_mem_busy)                // Busy is up from the next cycle.
                        state_nxt = ST_RUN;
        end
        default: state_nxt = state_q;          // Halted for good.
        endcase
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
                state_q <= ST_RUN;
        else
                state_q <= state_nxt;
end

// Load data and ALU results share one write port.
always_ff @(posedge i_clk)
begin
        if (i_load_wb.valid)
                regs_q[i_load_wb.rd] <= i_load_wb.data;
        else if (take && alu_wr)
                regs_q[ins.rd] <= alu_res;
end

assign o_halted = (state_q == ST_HALTED);

// One access at a time on the data side.
assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mem_req_valid |=> i_mem_busy);

endmodule

/* verilog/cpu_mem_access.sv */
`include "cpu_consts.svh"

module cpu_mem_access
(
        input   logic                           i_clk,
        input   logic                           i_rst_n,

        input   cpu_bus_pkg::mem_req_t          i_req,
        input   logic                           i_req_valid,

        input   logic   [`CPU_XLEN-1:0]         i_dram_data,
        input   logic                           i_dram_stall,
        output  logic                           o_dram_rd_en,
        output  logic                           o_dram_wr_en,
        output  logic   [`CPU_XLEN-1:0]         o_dram_addr,
        output  logic   [3:0]                   o_dram_ben,
        output  logic   [`CPU_XLEN-1:0]         o_dram_data,

        output  logic                           o_busy,
        output  cpu_bus_pkg::load_wb_t          o_load_wb
);

import cpu_bus_pkg::*;

mem_req_t                       req_q;
logic                           busy_q;
logic                           accept;
logic                           done;
logic                           wb_valid_q;
logic [$clog2(`CPU_NREGS)-1:0]  wb_rd_q;
logic [`CPU_XLEN-1:0]           wb_data_q;

assign accept = i_req_valid && !busy_q;
assign done   = busy_q && !i_dram_stall;        // First stall-low cycle.

// ======================================================================
// Request hold and completion.
// ======================================================================

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                busy_q     <= 1'b0;
                wb_valid_q <= 1'b0;
        end
        else
        begin
                if (accept)
                        busy_q <= 1'b1;
                else if (done)
                        busy_q <= 1'b0;

                wb_valid_q <= done && req_q.read;       // Stores return nothing.
        end
end

always_ff @(posedge i_clk)
begin
        if (accept)
                req_q <= i_req;

        if (done)
        begin
                wb_rd_q   <= req_q.rd;
                wb_data_q <= i_dram_data;
        end
end

assign o_dram_rd_en = busy_q && req_q.read;
assign o_dram_wr_en = busy_q && req_q.write;
assign o_dram_addr  = req_q.addr;
assign o_dram_ben   = req_q.ben;
assign o_dram_data  = req_q.wdata;
assign o_busy       = busy_q;

assign o_load_wb.valid = wb_valid_q;
assign o_load_wb.rd    = wb_rd_q;
assign o_load_wb.data  = wb_data_q;

// Execute never encodes a request that both reads and writes.
assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_dram_rd_en && o_dram_wr_en));

endmodule

/* verilog/cpu_top.sv */
`include "cpu_consts.svh"

module cpu_top
(
        // Clock and reset.
        input   logic                           i_clk,
        input   logic                           i_rst_n,

        // Simple data memory port.
        output  logic                           o_dram_wr_en,
        output  logic                           o_dram_rd_en,
        output  logic   [`CPU_XLEN-1:0]         o_dram_data,
        output  logic   [`CPU_XLEN-1:0]         o_dram_addr,
        output  logic   [3:0]                   o_dram_ben,
        input   logic   [`CPU_XLEN-1:0]         i_dram_data,
        input   logic                           i_dram_stall,

        // Simple instruction memory port.
        output  logic                           o_iram_rd_en,
        input   logic   [`CPU_XLEN-1:0]         i_iram_data,
        output  logic   [`CPU_XLEN-1:0]         o_iram_addr,
        input   logic                           i_iram_stall,

        output  logic                           o_halted
);

import cpu_isa_pkg::*;
import cpu_bus_pkg::*;

fetch_word_t            fw;
logic                   fw_valid;
logic                   hold;
logic                   redirect;
logic [`CPU_XLEN-1:0]   redirect_pc;
mem_req_t               mem_req;
logic                   mem_req_valid;
logic                   mem_busy;
load_wb_t               load_wb;

// ======================================================================
// Fetch, execute and memory access.
// ======================================================================

cpu_fetch u_fetch
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_iram_data    (i_iram_data),
        .i_iram_stall   (i_iram_stall),
        .i_hold         (hold),         // Lowest priority.
        .i_mem_busy     (mem_busy),
        .i_redirect     (redirect),     // Highest priority.
        .i_redirect_pc  (redirect_pc),
        .o_iram_rd_en   (o_iram_rd_en),
        .o_iram_addr    (o_iram_addr),
        .o_fw           (fw),
        .o_fw_valid     (fw_valid)
);

cpu_execute u_execute
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_fw           (fw),
        .i_fw_valid     (fw_valid),
        .i_mem_busy     (mem_busy),
        .i_load_wb      (load_wb),
        .o_hold         (hold),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_mem_req      (mem_req),
        .o_mem_req_valid(mem_req_valid),
        .o_halted       (o_halted)
);

cpu_mem_access u_mem_access
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_req          (mem_req),
        .i_req_valid    (mem_req_valid),
        .i_dram_data    (i_dram_data),
        .i_dram_stall   (i_dram_stall),
        .o_dram_rd_en   (o_dram_rd_en),
        .o_dram_wr_en   (o_dram_wr_en),
        .o_dram_addr    (o_dram_addr),
        .o_dram_ben     (o_dram_ben),
        .o_dram_data    (o_dram_data),
        .o_busy         (mem_busy),
        .o_load_wb      (load_wb)
);

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen
#(
        parameter real HALF_PERIOD = 4.0        // 8 ns clock.
)
(
        output  logic   o_clk
);

timeunit 1ns;
timeprecision 100ps;

initial
begin
        o_clk = 1'b0;
end

always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

/* testbench/tb_cpu_top.sv */
module tb_cpu_top;

timeunit 1ns;
timeprecision 100ps;

// Expected data memory write, as listed in the pattern file.
typedef struct packed
{
        logic [31:0]    addr;
        logic [3:0]     ben;
        logic [31:0]    data;
} store_rec_t;

logic           clk;
logic           i_rst_n;
logic           o_dram_wr_en;
logic           o_dram_rd_en;
logic [31:0]    o_dram_data;
logic [31:0]    o_dram_addr;
logic [3:0]     o_dram_ben;
logic [31:0]    i_dram_data;
logic           i_dram_stall;
logic           o_iram_rd_en;
logic [31:0]    i_iram_data;
logic [31:0]    o_iram_addr;
logic           i_iram_stall;
logic           o_halted;

logic [31:0]    pat [0:127];
logic [31:0]    imem [0:63];
logic [31:0]    dmem [0:63];
store_rec_t     exp_st [0:15];
int             n_prog;
int             n_st;
logic [31:0]    exp_halt_pc;
logic [31:0]    last_fetch_addr;
logic [31:0]    lfsr;
logic [1:0]     icnt;
logic [1:0]     dcnt;
logic           ibusy_prev;
logic           dbusy_prev;
logic [31:0]    iaddr_prev;
logic [69:0]    dreq_prev;
int             store_idx;
int             err_count;
int             stall_errs;
int             tests_run;
int             tests_failed;
int             cycles;
int             limit;

tb_clock_gen u_clk (.o_clk(clk));

cpu_top i_dut
(
        .i_clk          (clk),
        .i_rst_n        (i_rst_n),
        .o_dram_wr_en   (o_dram_wr_en),
        .o_dram_rd_en   (o_dram_rd_en),
        .o_dram_data    (o_dram_data),
        .o_dram_addr    (o_dram_addr),
        .o_dram_ben     (o_dram_ben),
        .i_dram_data    (i_dram_data),
        .i_dram_stall   (i_dram_stall),
        .o_iram_rd_en   (o_iram_rd_en),
        .i_iram_data    (i_iram_data),
        .o_iram_addr    (o_iram_addr),
        .i_iram_stall   (i_iram_stall),
        .o_halted       (o_halted)
);

// ======================================================================
// Helpers.
// ======================================================================

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
                return (s >> 1) ^ 32'h8020_0003;        // Galois taps.
        return s >> 1;
endfunction

// Two LFSR steps, one per bit of the 0 to 3 stall count.
task automatic draw_stall(output logic [1:0] n);
        lfsr = lfsr_step(lfsr);
        n[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        n[1] = lfsr[0];
endtask

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
                err_count++;
        end
endtask

task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before)
        begin
                tests_failed++;
                $display("test %s: failed", name);
        end
        else
        begin
                $display("test %s: passed", name);
        end
endtask

// ======================================================================
// Instruction and data memory models.
// ======================================================================

always @(posedge clk)
begin
        int e0;
        int e1;
        logic [31:0] w;

        if (!i_rst_n)
        begin
                i_iram_stall <= 1'b1;
                i_dram_stall <= 1'b1;
                ibusy_prev   = 1'b0;
                dbusy_prev   = 1'b0;
        end
        else
        begin
                // Request fields must hold while stalled.
                e0 = err_count;
                if (ibusy_prev)
                begin
                        compare("o_iram_rd_en", {31'd0, o_iram_rd_en}, 32'd1);
                        compare("o_iram_addr", o_iram_addr, iaddr_prev);
                end
                if (dbusy_prev)
                begin
                        compare("o_dram_rd_en", {31'd0, o_dram_rd_en}, {31'd0, dreq_prev[69]});
                        compare("o_dram_wr_en", {31'd0, o_dram_wr_en}, {31'd0, dreq_prev[68]});
                        compare("o_dram_addr", o_dram_addr, dreq_prev[63:32]);
                        compare("o_dram_ben", {28'd0, o_dram_ben}, {28'd0, dreq_prev[67:64]});
                        compare("o_dram_data", o_dram_data, dreq_prev[31:0]);
                end
                stall_errs += err_count - e0;
                ibusy_prev = o_iram_rd_en && i_iram_stall;
                iaddr_prev = o_iram_addr;
                dbusy_prev = (o_dram_rd_en || o_dram_wr_en) && i_dram_stall;
                dreq_prev  = {o_dram_rd_en, o_dram_wr_en, o_dram_ben,
                              o_dram_addr, o_dram_data};

                // Instruction port.
                if (o_iram_rd_en && !i_iram_stall)
                begin
                        if (!o_halted)
                                last_fetch_addr = o_iram_addr;
                        i_iram_stall <= 1'b1;
                        draw_stall(icnt);
                end
                else if (o_iram_rd_en)
                begin
                        if (icnt == 2'd0)
                        begin
                                i_iram_stall <= 1'b0;
                                i_iram_data  <= imem[o_iram_addr[7:2]];
                        end
                        else
                                icnt--;
                end

                // Data port.
                if ((o_dram_rd_en || o_dram_wr_en) && !i_dram_stall)
                begin
                        i_dram_stall <= 1'b1;
                        draw_stall(dcnt);
                        if (o_dram_wr_en)
                        begin
                                w = dmem[o_dram_addr[7:2]];
                                for (int b = 0; b < 4; b++)
                                        if (o_dram_ben[b])
                                                w[8*b +: 8] = o_dram_data[8*b +: 8];
                                dmem[o_dram_addr[7:2]] = w;

                                if (o_halted)
                                begin
                                        $display("Store to 0x%08h after halt", o_dram_addr);
                                        err_count++;
                                end
                                else if (store_idx >= n_st)
                                begin
                                        $display("Unexpected store to 0x%08h", o_dram_addr);
                                        err_count++;
                                end
                                else
                                begin
                                        e1 = err_count;
                                        compare("o_dram_addr", o_dram_addr, exp_st[store_idx].addr);
                                        compare("o_dram_ben", {28'd0, o_dram_ben},
                                                {28'd0, exp_st[store_idx].ben});
                                        compare("o_dram_data", o_dram_data, exp_st[store_idx].data);
                                        finish_test($sformatf("store %0d", store_idx + 1), e1);
                                end
                                store_idx++;
                        end
                end
                else if (o_dram_rd_en || o_dram_wr_en)
                begin
                        if (dcnt == 2'd0)
                        begin
                                i_dram_stall <= 1'b0;
                                i_dram_data  <= dmem[o_dram_addr[7:2]];
                        end
                        else
                                dcnt--;
                end
        end
end

// ======================================================================
// Sequence.
// ======================================================================

initial
begin
        int e0;

        i_rst_n      <= 1'b0;
        i_iram_stall <= 1'b1;
        i_iram_data  <= 32'd0;
        i_dram_stall <= 1'b1;
        i_dram_data  <= 32'd0;
        lfsr         = 32'hd48e;
        icnt         = 2'd0;
        dcnt         = 2'd0;
        store_idx    = 0;
        err_count    = 0;
        stall_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_fetch_addr = 32'hFFFF_FFFF;

        $readmemh("testbench/cpu_patterns.txt", pat);
        n_prog      = pat[0];
        n_st        = pat[1];
        exp_halt_pc = pat[2];
        for (int i = 0; i < 64; i++)
        begin
                imem[i] = 32'hE000_0000 + i;                    // NOP, index in imm.
                dmem[i] = 32'h1000_0000 + i * 32'h0001_0001;    // Unique per word.
        end
        for (int i = 0; i < n_prog; i++)
                imem[i] = pat[3 + i];
        for (int k = 0; k < n_st; k++)
                exp_st[k] = {pat[3 + n_prog + 3*k], pat[4 + n_prog + 3*k][3:0],
                             pat[5 + n_prog + 3*k]};
        limit = 40 * n_prog + 200;

        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;

        cycles = 0;
        while (!o_halted && cycles < limit)
        begin
                @(posedge clk);
                cycles++;
        end

        e0 = err_count;
        if (!o_halted)
        begin
                $display("Timeout: processor did not halt within %0d cycles", limit);
                err_count++;
        end
        else
                compare("last fetch address", last_fetch_addr, exp_halt_pc);
        finish_test("halt", e0);

        repeat (30) @(posedge clk);                     // Watch for late stores.

        e0 = err_count;
        compare("store count", store_idx, n_st);
        finish_test("store count", e0);

        tests_run++;
        if (stall_errs != 0)
        begin
                tests_failed++;
                $display("test stall stability: failed");
        end
        else
                $display("test stall stability: passed");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0)
                $display("RESULT: PASS");
        else
                $display("RESULT: FAIL");
        $finish;
end

endmodule

/* all.f */
+incdir+include
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/cpu_fetch.sv
verilog/cpu_execute.sv
verilog/cpu_mem_access.sv
verilog/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the CPU testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_cpu_top -o sim_cpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

/* testbench/cpu_patterns.txt */
// Header: program word count, expected store count, expected halt PC.
// Then program words, then stores as address, byte-enable, data.
0000001B 00000007 00000064
51001234 6200ABCD 03120000 80030010  // ADDI LUI ADD STW
14310000 45320000 36450000 27620000  // SUB XOR OR AND
5770FFFF 80070014 90010021 90070023  // ADDI STW STB STB
78000010 80080018 A0150001 80030030  // LDW STW BEQ wrong-path STW
B0110001 59000055 B0900001 80090034  // BNE ADDI BNE wrong-path STW
8009001C C0000017 80090038 7A90FFCB  // STW JMP wrong-path STW LDW
800A0024 D0000000 8009003C           // STW HALT STW after halt
00000010 0000000F ABCD1234
00000014 0000000F ABCCFFFF
00000021 00000002 00003400
00000023 00000008 FF000000
00000018 0000000F ABCD1234
0000001C 0000000F 00000055
00000024 0000000F FF083408
